//--- list.f
+incdir+src
src/csr_addr_pkg.sv
src/csr_field_pkg.sv
src/csr_bus_if.sv
src/csr_access_decode.sv
src/csr_trap_state.sv
src/csr_timer.sv
src/csr_save_read_port.sv
src/csr_top.sv
bench/csr_tb.sv

//--- Bender.yml
package:
  name: csr_block

sources:
  - include_dirs:
      - src
    files:
      - src/csr_addr_pkg.sv
      - src/csr_field_pkg.sv
      - src/csr_bus_if.sv
      - src/csr_access_decode.sv
      - src/csr_trap_state.sv
      - src/csr_timer.sv
      - src/csr_save_read_port.sv
      - src/csr_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/csr_tb.sv

//--- bench/csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_params.svh"

module csr_tb import csr_addr_pkg::*, csr_field_pkg::*;;

    localparam int HALF_PERIOD       = 20;
    localparam int RESET_CYCLES      = 5;
    localparam int MAX_INITVAL       = 10;
    localparam int OTHER_TEST_CYCLES = 200;
    // four timer waits, each bounded by 4*initval+20
    localparam int WATCHDOG_CYCLES   = RESET_CYCLES + OTHER_TEST_CYCLES
                                       + 4 * (4 * MAX_INITVAL + 20) + 100;

    logic      clk;
    logic      aresetn;
    logic      software_en;
    csr_addr_t addr;
    word_t     rdata;
    logic      wen;
    word_t     wdata;
    word_t     crmd;
    word_t     estat;
    word_t     era_out;
    word_t     eentry;
    logic      cpu_interrupt;
    logic      idle_over;
    logic      exception;
    logic      ertn;
    expcode_t  expcode_in;
    logic      wen_expcode;
    word_t     era_in;
    logic      wen_era;
    word_t     badv_in;
    logic      wen_badv;
    hw_irq_t   hardware_interrupt;

    logic [31:0] lfsr_state;
    int          fail_count;
    int          fails_at_start;
    int          tests_passed;
    int          tests_failed;
    logic [1:0]  mode_pats [5] = '{2'b11, 2'b00, 2'b10, 2'b11, 2'b01};

    csr_top dut_i (
        .clk                (clk),
        .aresetn            (aresetn),
        .software_en        (software_en),
        .addr               (addr),
        .rdata              (rdata),
        .wen                (wen),
        .wdata              (wdata),
        .crmd               (crmd),
        .estat              (estat),
        .era_out            (era_out),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over),
        .exception          (exception),
        .ertn               (ertn),
        .expcode_in         (expcode_in),
        .wen_expcode        (wen_expcode),
        .era_in             (era_in),
        .wen_era            (wen_era),
        .badv_in            (badv_in),
        .wen_badv           (wen_badv),
        .hardware_interrupt (hardware_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // hardware lines go straight into ESTAT.IS
    assert property (@(posedge clk) disable iff (!aresetn)
        estat[`ESTAT_IS_HARD] == hardware_interrupt)
        else begin
            $display("[FAIL] estat_hw_mirror: expected %h, actual %h",
                     hardware_interrupt, estat[`ESTAT_IS_HARD]);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        crmd[`CRMD_PG] != crmd[`CRMD_DA])
        else begin
            $display("CRMD left the legal modes, PG and DA are both %b", crmd[`CRMD_PG]);
            fail_count++;
        end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic word_t random_bits(input int nbits);
        word_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic expect_word(input string name, input word_t exp, input word_t act);
        assert (act === exp)
            else begin
                $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
                fail_count++;
            end
    endtask

    task automatic sw_write(input csr_addr_t a, input word_t d, input logic en = 1'b1);
        @(negedge clk);
        addr        = a;
        wdata       = d;
        software_en = en;
        wen         = 1'b1;
        @(negedge clk);
        software_en = 1'b0;
        wen         = 1'b0;
    endtask

    // rdata is combinational, sample mid low phase
    task automatic read_csr(input csr_addr_t a, output word_t d);
        @(negedge clk);
        addr = a;
        #(HALF_PERIOD / 2);
        d = rdata;
    endtask

    task automatic expect_read(input string name, input csr_addr_t a, input word_t exp);
        word_t d;
        read_csr(a, d);
        expect_word(name, exp, d);
    endtask

    task automatic expect_irq(input string name, input logic exp_cpu, input logic exp_idle);
        @(negedge clk);
        #(HALF_PERIOD / 2);
        expect_word({name, " cpu_interrupt"}, {31'd0, exp_cpu}, {31'd0, cpu_interrupt});
        expect_word({name, " idle_over"}, {31'd0, exp_idle}, {31'd0, idle_over});
    endtask

    task automatic wait_for_ti(input string name, input int limit);
        int   cycles;
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            seen = estat[`ESTAT_IS_TI];
        end
        assert (seen)
            else begin
                $display("%s: timer interrupt did not rise within %0d cycles", name, limit);
                fail_count++;
            end
    endtask

    task automatic start_test();
        fails_at_start = fail_count;
    endtask

    task automatic end_test(input string name);
        if (fail_count == fails_at_start) begin
            $display("done: %s ok", name);
            tests_passed++;
        end else begin
            $display("done: %s with %0d errors", name, fail_count - fails_at_start);
            tests_failed++;
        end
    endtask

    task automatic reset_values();
        start_test();
        expect_read("reset_values crmd", `CSR_CRMD, 32'h8);
        expect_read("reset_values prmd", `CSR_PRMD, '0);
        expect_read("reset_values ecfg", `CSR_ECFG, '0);
        expect_read("reset_values estat", `CSR_ESTAT, '0);
        expect_read("reset_values era", `CSR_ERA, '0);
        expect_read("reset_values badv", `CSR_BADV, '0);
        expect_read("reset_values eentry", `CSR_EENTRY, '0);
        for (int i = 0; i < 4; i++) begin
            expect_read("reset_values save", csr_addr_t'(`CSR_SAVE0 + i), '0);
        end
        expect_read("reset_values tcfg", `CSR_TCFG, '0);
        expect_read("reset_values tval", `CSR_TVAL, '0);
        expect_read("reset_values ticlr", `CSR_TICLR, '0);
        expect_irq("reset_values", 1'b0, 1'b0);
        end_test("reset_values");
    endtask

    task automatic rw_masks();
        word_t d;
        word_t save0;
        start_test();
        save0 = '0;
        for (int i = 0; i < 4; i++) begin
            d = random_bits(32);
            if (i == 0) begin
                save0 = d;
            end
            sw_write(csr_addr_t'(`CSR_SAVE0 + i), d);
            expect_read("rw_masks save", csr_addr_t'(`CSR_SAVE0 + i), d);
        end
        d = random_bits(32);
        sw_write(`CSR_ERA, d);
        expect_read("rw_masks era", `CSR_ERA, d);
        expect_word("rw_masks era_out", d, era_out);
        d = random_bits(32);
        sw_write(`CSR_BADV, d);
        expect_read("rw_masks badv", `CSR_BADV, d);
        // entry address is 64-byte aligned
        d = random_bits(32);
        sw_write(`CSR_EENTRY, d);
        expect_read("rw_masks eentry", `CSR_EENTRY, d & 32'hffff_ffc0);
        expect_word("rw_masks eentry port", d & 32'hffff_ffc0, eentry);
        sw_write(14'h010, random_bits(32));
        expect_read("rw_masks unmapped", 14'h010, '0);
        sw_write(`CSR_SAVE0, ~save0, 1'b0);
        expect_read("rw_masks gated write", `CSR_SAVE0, save0);
        end_test("rw_masks");
    endtask

    task automatic trans_mode();
        word_t      d;
        word_t      exp_crmd;
        logic [1:0] mode;
        start_test();
        // {pg, da}, direct after reset
        mode = 2'b01;
        for (int i = 0; i < 5; i++) begin
            d = random_bits(32);
            d[`CRMD_PG] = mode_pats[i][1];
            d[`CRMD_DA] = mode_pats[i][0];
            if (mode_pats[i][1] != mode_pats[i][0]) begin
                mode = mode_pats[i];
            end
            sw_write(`CSR_CRMD, d);
            exp_crmd = (d & 32'h1e7) | {27'd0, mode, 3'd0};
            expect_read("trans_mode crmd", `CSR_CRMD, exp_crmd);
            expect_word("trans_mode crmd port", exp_crmd, crmd);
        end
        sw_write(`CSR_CRMD, 32'h8);
        end_test("trans_mode");
    endtask

    task automatic trap_entry_return();
        word_t    v;
        ecode_t   code;
        logic     flag;
        start_test();
        sw_write(`CSR_CRMD, 32'h0f);
        expect_read("trap_entry_return crmd setup", `CSR_CRMD, 32'h0f);
        // exception and a software crmd write in the same cycle
        @(negedge clk);
        exception   = 1'b1;
        addr        = `CSR_CRMD;
        wdata       = 32'h17;
        software_en = 1'b1;
        wen         = 1'b1;
        @(negedge clk);
        exception   = 1'b0;
        software_en = 1'b0;
        wen         = 1'b0;
        expect_read("trap_entry_return crmd entry", `CSR_CRMD, 32'h08);
        expect_read("trap_entry_return prmd entry", `CSR_PRMD, 32'h07);
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        expect_read("trap_entry_return crmd ertn", `CSR_CRMD, 32'h0f);

        code = ecode_t'(random_bits(6));
        if (code == '0) begin
            code = 6'd1;
        end
        v    = random_bits(1);
        flag = v[0];
        @(negedge clk);
        expcode_in  = {flag, code};
        wen_expcode = 1'b1;
        @(negedge clk);
        wen_expcode = 1'b0;
        expect_read("trap_entry_return ecode", `CSR_ESTAT,
                    ({26'd0, code} << 16) | ({31'd0, flag} << 22));
        // a zero code never carries a subcode
        @(negedge clk);
        expcode_in  = 7'h40;
        wen_expcode = 1'b1;
        @(negedge clk);
        wen_expcode = 1'b0;
        expect_read("trap_entry_return ecode zero", `CSR_ESTAT, '0);

        v = random_bits(32);
        @(negedge clk);
        era_in      = v;
        wen_era     = 1'b1;
        addr        = `CSR_ERA;
        wdata       = ~v;
        software_en = 1'b1;
        wen         = 1'b1;
        @(negedge clk);
        wen_era     = 1'b0;
        software_en = 1'b0;
        wen         = 1'b0;
        expect_read("trap_entry_return era", `CSR_ERA, v);
        expect_word("trap_entry_return era_out", v, era_out);
        v = random_bits(32);
        @(negedge clk);
        badv_in  = v;
        wen_badv = 1'b1;
        @(negedge clk);
        wen_badv = 1'b0;
        expect_read("trap_entry_return badv", `CSR_BADV, v);
        sw_write(`CSR_CRMD, 32'h8);
        end_test("trap_entry_return");
    endtask

    task automatic interrupt_gating();
        hw_irq_t hw;
        word_t   lines;
        start_test();
        hw = hw_irq_t'(random_bits(8)) | 8'h01;
        lines = {24'd0, hw} << 2;
        @(negedge clk);
        hardware_interrupt = hw;
        expect_read("interrupt_gating estat", `CSR_ESTAT, lines);
        // enabled lines pending, but ie still off
        sw_write(`CSR_ECFG, lines);
        expect_irq("interrupt_gating ie off", 1'b0, 1'b1);
        sw_write(`CSR_CRMD, 32'h0c);
        expect_irq("interrupt_gating enabled", 1'b1, 1'b1);
        sw_write(`CSR_ECFG, ~lines & 32'h1fff);
        expect_irq("interrupt_gating masked", 1'b0, 1'b1);
        @(negedge clk);
        hardware_interrupt = '0;
        // software bit 0 is still enabled in lie
        sw_write(`CSR_ESTAT, 32'h1);
        expect_read("interrupt_gating soft", `CSR_ESTAT, 32'h1);
        expect_irq("interrupt_gating soft", 1'b1, 1'b1);
        sw_write(`CSR_ECFG, '0);
        expect_irq("interrupt_gating soft masked", 1'b0, 1'b1);
        sw_write(`CSR_ESTAT, '0);
        expect_irq("interrupt_gating idle", 1'b0, 1'b0);
        sw_write(`CSR_CRMD, 32'h8);
        end_test("interrupt_gating");
    endtask

    task automatic timer_tick();
        int    iv;
        int    limit;
        word_t d;
        start_test();
        iv = 3 + int'(random_bits(3));
        limit = 4 * iv + 8;
        sw_write(`CSR_TCFG, (word_t'(iv) << 2) | 32'h1);
        expect_read("timer_tick tcfg", `CSR_TCFG, (word_t'(iv) << 2) | 32'h1);
        wait_for_ti("timer_tick one-shot", limit - 2);
        repeat (4) @(negedge clk);
        expect_word("timer_tick held", 32'd1, {31'd0, estat[`ESTAT_IS_TI]});
        sw_write(`CSR_TICLR, 32'h1);
        read_csr(`CSR_ESTAT, d);
        expect_word("timer_tick cleared", '0, {31'd0, d[`ESTAT_IS_TI]});

        sw_write(`CSR_TCFG, (word_t'(iv) << 2) | 32'h3);
        wait_for_ti("timer_tick periodic", limit - 1);
        sw_write(`CSR_TICLR, 32'h1);
        read_csr(`CSR_ESTAT, d);
        expect_word("timer_tick periodic cleared", '0, {31'd0, d[`ESTAT_IS_TI]});
        wait_for_ti("timer_tick periodic again", limit);
        sw_write(`CSR_TCFG, '0);
        sw_write(`CSR_TICLR, 32'h1);
        // a disabled timer stays quiet for longer than one period
        repeat (limit) @(negedge clk);
        read_csr(`CSR_ESTAT, d);
        expect_word("timer_tick stopped", '0, {31'd0, d[`ESTAT_IS_TI]});
        end_test("timer_tick");
    endtask

    initial begin
        lfsr_state         = 32'h15ca119f;
        fail_count         = 0;
        fails_at_start     = 0;
        tests_passed       = 0;
        tests_failed       = 0;
        aresetn            = 1'b0;
        software_en        = 1'b0;
        addr               = '0;
        wen                = 1'b0;
        wdata              = '0;
        exception          = 1'b0;
        ertn               = 1'b0;
        expcode_in         = '0;
        wen_expcode        = 1'b0;
        era_in             = '0;
        wen_era            = 1'b0;
        badv_in            = '0;
        wen_badv           = 1'b0;
        hardware_interrupt = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;

        reset_values();
        rw_masks();
        trans_mode();
        trap_entry_return();
        interrupt_gating();
        timer_tick();

        $display("summary: %0d tests passed, %0d tests failed, %0d check failures",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/csr_top.sv
`timescale 1ns/100ps
`default_nettype none

module csr_top import csr_addr_pkg::*, csr_field_pkg::*; (
    input  logic      clk,
    input  logic      aresetn,

    // software access
    input  logic      software_en,
    input  csr_addr_t addr,
    output word_t     rdata,
    input  logic      wen,
    input  word_t     wdata,

    output word_t     crmd,
    output word_t     estat,
    output word_t     era_out,
    output word_t     eentry,
    output logic      cpu_interrupt,
    output logic      idle_over,

    // trap capture from the pipeline
    input  logic      exception,
    input  logic      ertn,
    input  expcode_t  expcode_in,
    input  logic      wen_expcode,
    input  word_t     era_in,
    input  logic      wen_era,
    input  word_t     badv_in,
    input  logic      wen_badv,
    input  hw_irq_t   hardware_interrupt
);

    logic ti_pending;

    csr_bus_if bus_i ();

    csr_access_decode decode_i (
        .addr        (addr),
        .software_en (software_en),
        .wen         (wen),
        .wdata       (wdata),
        .bus         (bus_i.decoder)
    );

    csr_trap_state trap_i (
        .clk                (clk),
        .aresetn            (aresetn),
        .exception          (exception),
        .ertn               (ertn),
        .expcode_in         (expcode_in),
        .wen_expcode        (wen_expcode),
        .era_in             (era_in),
        .wen_era            (wen_era),
        .badv_in            (badv_in),
        .wen_badv           (wen_badv),
        .hardware_interrupt (hardware_interrupt),
        .ti_pending         (ti_pending),
        .crmd               (crmd),
        .estat              (estat),
        .era_out            (era_out),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over),
        .bus                (bus_i.trap)
    );

    csr_timer timer_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .ti_pending (ti_pending),
        .bus        (bus_i.timer)
    );

    csr_save_read_port read_i (
        .clk     (clk),
        .aresetn (aresetn),
        .rdata   (rdata),
        .bus     (bus_i.reader)
    );

endmodule

`default_nettype wire

//--- src/csr_save_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module csr_save_read_port import csr_addr_pkg::*, csr_field_pkg::*; (
    input  logic         clk,
    input  logic         aresetn,
    output word_t        rdata,
    csr_bus_if.reader    bus
);

    word_t      save_q [4];
    logic [1:0] save_idx;
    logic       save_hit;
    word_t      save_rdata;

    always_comb begin
        save_hit = 1'b1;
        case (bus.sel)
            SEL_SAVE0: save_idx = 2'd0;
            SEL_SAVE1: save_idx = 2'd1;
            SEL_SAVE2: save_idx = 2'd2;
            SEL_SAVE3: save_idx = 2'd3;
            default: begin
                save_idx = 2'd0;
                save_hit = 1'b0;
            end
        endcase
    end

    // scratch words, software owns every bit
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            save_q <= '{default: '0};
        end else if (bus.wr && save_hit) begin
            save_q[save_idx] <= bus.wdata;
        end
    end

    assign save_rdata = save_hit ? save_q[save_idx] : '0;

    // each bank drives zero unless selected, so or-ing is enough
    assign rdata = save_rdata | bus.trap_rdata | bus.timer_rdata;

endmodule

`default_nettype wire

//--- src/csr_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_params.svh"

module csr_timer import csr_addr_pkg::*, csr_field_pkg::*; (
    input  logic        clk,
    input  logic        aresetn,
    output logic        ti_pending,
    csr_bus_if.timer    bus
);

    logic     tcfg_en;
    logic     tcfg_periodic;
    initval_t tcfg_initval;
    word_t    tval;
    word_t    tcfg_w;
    logic     reload_pend;
    logic     time_out;
    logic     wr_tcfg;
    logic     wr_ticlr;

    assign wr_tcfg  = bus.wr && (bus.sel == SEL_TCFG);
    assign wr_ticlr = bus.wr && (bus.sel == SEL_TICLR);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            reload_pend   <= 1'b0;
        end else begin
            if (wr_tcfg) begin
                tcfg_en       <= bus.wdata[`TCFG_EN];
                tcfg_periodic <= bus.wdata[`TCFG_PERIODIC];
                tcfg_initval  <= bus.wdata[`TCFG_INITVAL];
            end
            // tval picks up the new initval one edge after the write
            reload_pend <= wr_tcfg;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else begin
            time_out <= 1'b0;
            if (reload_pend || (tval == '0 && tcfg_periodic)) begin
                tval <= {tcfg_initval, `CSR_TIMER_PAD};
            end else if (tval != '0 && tcfg_en) begin
                tval     <= tval - 1'b1;
                time_out <= (tval == 32'd1);
            end
        end
    end

    // clear wins over a timeout in the same cycle
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti_pending <= 1'b0;
        end else if (wr_ticlr && bus.wdata[`TICLR_CLR]) begin
            ti_pending <= 1'b0;
        end else if (time_out) begin
            ti_pending <= 1'b1;
        end
    end

    always_comb begin
        tcfg_w                 = '0;
        tcfg_w[`TCFG_EN]       = tcfg_en;
        tcfg_w[`TCFG_PERIODIC] = tcfg_periodic;
        tcfg_w[`TCFG_INITVAL]  = tcfg_initval;
    end

    always_comb begin
        case (bus.sel)
            SEL_TCFG:  bus.timer_rdata = tcfg_w;
            SEL_TVAL:  bus.timer_rdata = tval;
            // ticlr is write-only
            SEL_TICLR: bus.timer_rdata = '0;
            default:   bus.timer_rdata = '0;
        endcase
    end

    // ti_pending rises only after tval stepped from 1 to 0
    assert property (@(posedge clk) disable iff (!aresetn)
        $rose(ti_pending) |-> ($past(tval, 2) == 32'd1));

endmodule

`default_nettype wire

//--- src/csr_trap_state.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_params.svh"

module csr_trap_state import csr_addr_pkg::*, csr_field_pkg::*; (
    input  logic       clk,
    input  logic       aresetn,
    input  logic       exception,
    input  logic       ertn,
    input  expcode_t   expcode_in,
    input  logic       wen_expcode,
    input  word_t      era_in,
    input  logic       wen_era,
    input  word_t      badv_in,
    input  logic       wen_badv,
    input  hw_irq_t    hardware_interrupt,
    input  logic       ti_pending,
    output word_t      crmd,
    output word_t      estat,
    output word_t      era_out,
    output word_t      eentry,
    output logic       cpu_interrupt,
    output logic       idle_over,
    csr_bus_if.trap    bus
);

    localparam word_t CRMD_RESET = `CSR_CRMD_RESET;

    plv_t        crmd_plv;
    logic        crmd_ie;
    trans_mode_t crmd_mode;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    irq_lines_t  ecfg_lie;
    logic [1:0]  estat_is_soft;
    ecode_t      estat_ecode;
    logic [8:0]  estat_esubcode;
    word_t       era_q;
    word_t       badv_q;
    logic [25:0] eentry_va;
    irq_lines_t  is_lines;
    word_t       prmd_w;
    word_t       ecfg_w;
    logic        wr_crmd;
    logic        wr_prmd;
    logic        wr_ecfg;
    logic        wr_estat;
    logic        wr_era;
    logic        wr_badv;
    logic        wr_eentry;

    assign wr_crmd   = bus.wr && (bus.sel == SEL_CRMD);
    assign wr_prmd   = bus.wr && (bus.sel == SEL_PRMD);
    assign wr_ecfg   = bus.wr && (bus.sel == SEL_ECFG);
    assign wr_estat  = bus.wr && (bus.sel == SEL_ESTAT);
    assign wr_era    = bus.wr && (bus.sel == SEL_ERA);
    assign wr_badv   = bus.wr && (bus.sel == SEL_BADV);
    assign wr_eentry = bus.wr && (bus.sel == SEL_EENTRY);

    // crmd: ertn, then exception, then software
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= CRMD_RESET[`CRMD_PLV];
            crmd_ie   <= CRMD_RESET[`CRMD_IE];
            crmd_mode <= CRMD_RESET[`CRMD_PG] ? TM_PAGED : TM_DIRECT;
            crmd_datf <= CRMD_RESET[`CRMD_DATF];
            crmd_datm <= CRMD_RESET[`CRMD_DATM];
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (exception) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wr_crmd) begin
            crmd_plv  <= bus.wdata[`CRMD_PLV];
            crmd_ie   <= bus.wdata[`CRMD_IE];
            crmd_datf <= bus.wdata[`CRMD_DATF];
            crmd_datm <= bus.wdata[`CRMD_DATM];
            // pg == da would be illegal, keep the old mode then
            if (bus.wdata[`CRMD_PG] != bus.wdata[`CRMD_DA]) begin
                crmd_mode <= bus.wdata[`CRMD_PG] ? TM_PAGED : TM_DIRECT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exception && !ertn) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd && !ertn) begin
            prmd_pplv <= bus.wdata[`PRMD_PPLV];
            prmd_pie  <= bus.wdata[`PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie      <= '0;
            estat_is_soft <= '0;
            eentry_va     <= '0;
        end else begin
            if (wr_ecfg) begin
                ecfg_lie <= bus.wdata[`ECFG_LIE];
            end
            if (wr_estat) begin
                estat_is_soft <= bus.wdata[`ESTAT_IS_SOFT];
            end
            if (wr_eentry) begin
                eentry_va <= bus.wdata[`EENTRY_VA];
            end
        end
    end

    // exception code only comes from the pipeline
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wen_expcode) begin
            estat_ecode    <= expcode_in[5:0];
            estat_esubcode <= (expcode_in[5:0] == '0) ? 9'd0 : {8'd0, expcode_in[6]};
        end
    end

    // capture strobes beat software
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_q  <= '0;
            badv_q <= '0;
        end else begin
            if (wen_era) begin
                era_q <= era_in;
            end else if (wr_era) begin
                era_q <= bus.wdata;
            end
            if (wen_badv) begin
                badv_q <= badv_in;
            end else if (wr_badv) begin
                badv_q <= bus.wdata;
            end
        end
    end

    // ipi bit 12 and bit 10 stay zero
    always_comb begin
        is_lines                 = '0;
        is_lines[`ESTAT_IS_SOFT] = estat_is_soft;
        is_lines[`ESTAT_IS_HARD] = hardware_interrupt;
        is_lines[`ESTAT_IS_TI]   = ti_pending;
    end

    always_comb begin
        crmd            = '0;
        crmd[`CRMD_PLV]  = crmd_plv;
        crmd[`CRMD_IE]   = crmd_ie;
        crmd[`CRMD_DA]   = crmd_mode[0];
        crmd[`CRMD_PG]   = crmd_mode[1];
        crmd[`CRMD_DATF] = crmd_datf;
        crmd[`CRMD_DATM] = crmd_datm;

        prmd_w             = '0;
        prmd_w[`PRMD_PPLV] = prmd_pplv;
        prmd_w[`PRMD_PIE]  = prmd_pie;

        ecfg_w            = '0;
        ecfg_w[`ECFG_LIE] = ecfg_lie;

        estat                  = '0;
        estat[`ESTAT_IS]       = is_lines;
        estat[`ESTAT_ECODE]    = estat_ecode;
        estat[`ESTAT_ESUBCODE] = estat_esubcode;

        eentry             = '0;
        eentry[`EENTRY_VA] = eentry_va;
    end

    assign era_out       = era_q;
    assign cpu_interrupt = crmd_ie && ((ecfg_lie & is_lines) != '0);
    // any pending line wakes idle, enabled or not
    assign idle_over     = (is_lines != '0);

    always_comb begin
        case (bus.sel)
            SEL_CRMD:   bus.trap_rdata = crmd;
            SEL_PRMD:   bus.trap_rdata = prmd_w;
            SEL_ECFG:   bus.trap_rdata = ecfg_w;
            SEL_ESTAT:  bus.trap_rdata = estat;
            SEL_ERA:    bus.trap_rdata = era_q;
            SEL_BADV:   bus.trap_rdata = badv_q;
            SEL_EENTRY: bus.trap_rdata = eentry;
            default:    bus.trap_rdata = '0;
        endcase
    end

    // translation mode only moves on a software crmd write that no trap overrides
    assert property (@(posedge clk) disable iff (!aresetn)
        (crmd_mode != $past(crmd_mode)) |-> $past(wr_crmd && !ertn && !exception));

endmodule

`default_nettype wire

//--- src/csr_access_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_params.svh"

module csr_access_decode import csr_addr_pkg::*, csr_field_pkg::*; (
    input  csr_addr_t         addr,
    input  logic              software_en,
    input  logic              wen,
    input  word_t             wdata,
    csr_bus_if.decoder        bus
);

    // select follows addr even without software_en, reads are ungated
    always_comb begin
        case (addr)
            `CSR_CRMD:   bus.sel = SEL_CRMD;
            `CSR_PRMD:   bus.sel = SEL_PRMD;
            `CSR_ECFG:   bus.sel = SEL_ECFG;
            `CSR_ESTAT:  bus.sel = SEL_ESTAT;
            `CSR_ERA:    bus.sel = SEL_ERA;
            `CSR_BADV:   bus.sel = SEL_BADV;
            `CSR_EENTRY: bus.sel = SEL_EENTRY;
            `CSR_SAVE0:  bus.sel = SEL_SAVE0;
            `CSR_SAVE1:  bus.sel = SEL_SAVE1;
            `CSR_SAVE2:  bus.sel = SEL_SAVE2;
            `CSR_SAVE3:  bus.sel = SEL_SAVE3;
            `CSR_TCFG:   bus.sel = SEL_TCFG;
            `CSR_TVAL:   bus.sel = SEL_TVAL;
            `CSR_TICLR:  bus.sel = SEL_TICLR;
            default:     bus.sel = SEL_NONE;
        endcase
    end

    assign bus.wr    = software_en & wen;
    assign bus.wdata = wdata;

    // an unknown address would quietly decode as a hole in the map
    always_comb begin
        assert final (!$isunknown({addr, bus.wr}));
    end

endmodule

`default_nettype wire

//--- src/csr_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface csr_bus_if import csr_addr_pkg::*, csr_field_pkg::*; ();

    csr_sel_t sel;
    logic     wr;
    word_t    wdata;
    word_t    trap_rdata;
    word_t    timer_rdata;

    modport decoder (
        output sel,
        output wr,
        output wdata
    );

    modport trap (
        input  sel,
        input  wr,
        input  wdata,
        output trap_rdata
    );

    modport timer (
        input  sel,
        input  wr,
        input  wdata,
        output timer_rdata
    );

    // read merge plus the scratch registers
    modport reader (
        input  sel,
        input  wr,
        input  wdata,
        input  trap_rdata,
        input  timer_rdata
    );

endinterface

`default_nettype wire

//--- src/csr_field_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_field_pkg;

    typedef logic [`CSR_XLEN-1:0] word_t;
    typedef logic [1:0]           plv_t;
    typedef logic [5:0]           ecode_t;
    // bit 6 carries the subcode flag
    typedef logic [6:0]           expcode_t;
    typedef logic [12:0]          irq_lines_t;
    typedef logic [7:0]           hw_irq_t;
    typedef logic [29:0]          initval_t;

    // encoded as {pg, da}, only the two legal states
    typedef enum logic [1:0] {
        TM_DIRECT = 2'b01,
        TM_PAGED  = 2'b10
    } trans_mode_t;

endpackage

`default_nettype wire

//--- src/csr_addr_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_addr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // one entry per kept register, SEL_NONE for holes in the map
    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECFG,
        SEL_ESTAT,
        SEL_ERA,
        SEL_BADV,
        SEL_EENTRY,
        SEL_SAVE0,
        SEL_SAVE1,
        SEL_SAVE2,
        SEL_SAVE3,
        SEL_TCFG,
        SEL_TVAL,
        SEL_TICLR
    } csr_sel_t;

endpackage

`default_nettype wire

//--- src/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 14

// csr numbers of the kept registers
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECFG   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_BADV   14'h007
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// direct translation after reset
`define CSR_CRMD_RESET 32'h0000_0008
// low bits of tval on load, so initval 0 still expires
`define CSR_TIMER_PAD  2'd1

`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ECFG_LIE        12:0
`define ESTAT_IS        12:0
`define ESTAT_IS_SOFT   1:0
`define ESTAT_IS_HARD   9:2
`define ESTAT_IS_TI     11
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22
`define EENTRY_VA       31:6
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

`endif
